// ==== Makefile ====
SRCS := $(shell cat files.f)

obj_dir/Vtlc_driver_tb: files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tlc_driver_tb -f files.f

.PHONY: run clean

run: obj_dir/Vtlc_driver_tb
	@out=$$(./obj_dir/Vtlc_driver_tb); echo "$$out"; echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir

// ==== design/credit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int DEPTH = 4
) (
    input  logic     clk,
    input  logic     nrst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_push;
    logic do_pop;

    // Sender never exceeds its credits, the full check is only a guard
    assign do_push = push && (count != CNT_W'(DEPTH));
    assign do_pop = pop && not_empty;

    assign not_empty = (count != '0);
    assign head = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap at DEPTH so any depth works
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credit <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
            // One credit back to the sender for each word freed
            credit <= do_pop;
        end
    end

endmodule

`default_nettype wire

// ==== design/driver_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module driver_controller #(
    parameter int BLANKING_TIME = 72
) (
    input  logic                clk,
    input  logic                nrst,
    input  logic                clk_enable,
    input  logic                position_sync,
    input  logic                cfg_present,
    input  logic                new_cfg,
    output tlc_pkg::drv_state_t state,
    output logic [7:0]          bit_index,
    output logic                sclk_en,
    output logic                gclk_en,
    output logic                lat_req,
    output logic                gs_take,
    output logic                cfg_load,
    output logic                column_ready
);

    logic [7:0] state_cnt;
    logic [9:0] segment_cnt;
    logic [2:0] row_cnt;
    logic [7:0] shift_cnt;
    logic blanking;
    logic reconfig;
    logic segment_end;

    // New config only interrupts streaming or the slice wait
    assign reconfig = new_cfg
                      && (state == tlc_pkg::STREAM || state == tlc_pkg::WAIT_FOR_NEXT_SLICE);
    assign cfg_load = clk_enable && ((state == tlc_pkg::STALL && cfg_present) || reconfig);

    assign segment_end = (segment_cnt == 10'(tlc_pkg::SEGMENT_LAST));

    // Blanking at the start of the segment keeps clear of LATGS
    assign blanking = (segment_cnt < 10'(BLANKING_TIME));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= tlc_pkg::STALL;
            state_cnt <= '0;
        end else if (clk_enable) begin
            state_cnt <= state_cnt + 1'b1;
            case (state)
                tlc_pkg::STALL: begin
                    state_cnt <= '0;
                    if (cfg_present) begin
                        state <= tlc_pkg::PREPARE_CONFIG;
                    end
                end
                // FCWRTEN
                tlc_pkg::PREPARE_CONFIG: begin
                    if (state_cnt == 8'(tlc_pkg::FCWRTEN_LEN - 1)) begin
                        state <= tlc_pkg::CONFIG;
                        state_cnt <= '0;
                    end
                end
                // One paused pulse then 48 data bits
                tlc_pkg::CONFIG: begin
                    if (state_cnt == 8'(tlc_pkg::FC_BITS)) begin
                        state <= tlc_pkg::WRTFC_TIMING;
                        state_cnt <= '0;
                    end
                end
                tlc_pkg::WRTFC_TIMING: begin
                    if (state_cnt == 8'(tlc_pkg::WRTFC_LEN)) begin
                        state <= tlc_pkg::PREPARE_DUMP_CONFIG;
                        state_cnt <= '0;
                    end
                end
                // READFC
                tlc_pkg::PREPARE_DUMP_CONFIG: begin
                    if (state_cnt == 8'(tlc_pkg::READFC_LEN - 1)) begin
                        state <= tlc_pkg::DUMP_CONFIG;
                        state_cnt <= '0;
                    end
                end
                tlc_pkg::DUMP_CONFIG: begin
                    if (state_cnt == 8'(tlc_pkg::FC_BITS + tlc_pkg::DUMP_PAUSE - 1)) begin
                        state <= tlc_pkg::LOD;
                        state_cnt <= '0;
                    end
                end
                // Open detection not done, single pass-through pulse
                tlc_pkg::LOD: begin
                    state <= tlc_pkg::WAIT_FOR_NEXT_SLICE;
                    state_cnt <= '0;
                end
                tlc_pkg::STREAM: begin
                    state_cnt <= '0;
                    if (row_cnt == 3'(tlc_pkg::MUX_ROWS - 1) && segment_end) begin
                        state <= tlc_pkg::WAIT_FOR_NEXT_SLICE;
                    end
                end
                tlc_pkg::WAIT_FOR_NEXT_SLICE: begin
                    state_cnt <= '0;
                    if (position_sync) begin
                        state <= tlc_pkg::STREAM;
                    end
                end
                default: begin
                    state <= tlc_pkg::STALL;
                    state_cnt <= '0;
                end
            endcase
            if (reconfig) begin
                state <= tlc_pkg::PREPARE_CONFIG;
                state_cnt <= '0;
            end
        end
    end

    // Segment and mux row position within the slice
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            segment_cnt <= '0;
            row_cnt <= '0;
        end else if (clk_enable) begin
            if (state == tlc_pkg::STREAM) begin
                if (segment_end) begin
                    segment_cnt <= '0;
                    row_cnt <= row_cnt + 1'b1;
                end else begin
                    segment_cnt <= segment_cnt + 1'b1;
                end
            end else begin
                segment_cnt <= '0;
                row_cnt <= '0;
            end
        end
    end

    // Shift position, 0 is the SCLK pause after each WRTFC or WRTGS
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            shift_cnt <= '0;
        end else if (clk_enable) begin
            case (state)
                tlc_pkg::CONFIG: begin
                    shift_cnt <= (shift_cnt == 8'(tlc_pkg::FC_BITS)) ? '0 : shift_cnt + 1'b1;
                end
                tlc_pkg::DUMP_CONFIG: begin
                    if (shift_cnt == 8'(tlc_pkg::FC_BITS + tlc_pkg::DUMP_PAUSE - 1)) begin
                        shift_cnt <= '0;
                    end else begin
                        shift_cnt <= shift_cnt + 1'b1;
                    end
                end
                tlc_pkg::STREAM: begin
                    // Held during blanking
                    if (blanking || shift_cnt == 8'(tlc_pkg::FC_BITS)) begin
                        shift_cnt <= '0;
                    end else begin
                        shift_cnt <= shift_cnt + 1'b1;
                    end
                end
                default: shift_cnt <= '0;
            endcase
        end
    end

    assign bit_index = shift_cnt;

    // Clock enables and LAT requests per state
    always_comb begin
        sclk_en = 1'b0;
        gclk_en = 1'b0;
        lat_req = 1'b0;
        case (state)
            tlc_pkg::PREPARE_CONFIG, tlc_pkg::PREPARE_DUMP_CONFIG: begin
                sclk_en = 1'b1;
                lat_req = 1'b1;
            end
            tlc_pkg::CONFIG: begin
                sclk_en = (shift_cnt != '0);
                // WRTFC over the last bits
                lat_req = (shift_cnt >= 8'(tlc_pkg::FC_BITS + 1 - tlc_pkg::WRTFC_LEN));
            end
            tlc_pkg::DUMP_CONFIG: begin
                sclk_en = (shift_cnt >= 8'(tlc_pkg::DUMP_PAUSE));
            end
            tlc_pkg::STREAM: begin
                sclk_en = !blanking && shift_cnt != '0;
                // GCLK rests one pulse after LATGS
                gclk_en = (segment_cnt != '0);
                // WRTGS per 48 bits, LATGS closing the segment
                lat_req = (shift_cnt >= 8'(tlc_pkg::FC_BITS + 1 - tlc_pkg::WRTGS_LEN))
                          || (segment_cnt >= 10'(tlc_pkg::SEGMENT_LAST + 1 - tlc_pkg::LATGS_LEN));
            end
            default: begin
            end
        endcase
    end

    assign gs_take = (state == tlc_pkg::STREAM) && sclk_en;
    assign column_ready = clk_enable && state == tlc_pkg::STREAM && segment_end;

endmodule

`default_nettype wire

// ==== design/driver_pin_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module driver_pin_mux (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  clk_enable,
    input  tlc_pkg::drv_state_t   state,
    input  logic                  sclk_en,
    input  logic                  gclk_en,
    input  logic                  lat_req,
    input  logic                  gs_take,
    input  logic                  fc_bit,
    input  tlc_pkg::gs_word_t     gs_head,
    input  logic                  gs_present,
    output logic                  gs_pop,
    output tlc_pkg::driver_pins_t pins,
    output logic                  underrun
);

    logic lat_q;
    logic gs_shift;

    assign gs_shift = gs_take && clk_enable;
    assign gs_pop = gs_shift && gs_present;

    // LAT moves on the falling edge for hold after SCLK
    always_ff @(negedge clk or negedge nrst) begin
        if (!nrst) begin
            lat_q <= 1'b0;
        end else begin
            lat_q <= lat_req;
        end
    end

    // Sticky until reset
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            underrun <= 1'b0;
        end else if (gs_shift && !gs_present) begin
            underrun <= 1'b1;
        end
    end

    always_comb begin
        pins.sclk = sclk_en && clk_enable;
        pins.gclk = gclk_en && clk_enable;
        pins.lat = lat_q;
        case (state)
            // Same config bit goes to every driver
            tlc_pkg::CONFIG: pins.sin = {tlc_pkg::LANES{fc_bit}};
            // Empty buffer shifts zeros
            tlc_pkg::STREAM: pins.sin = (gs_take && gs_present) ? gs_head : '0;
            default: pins.sin = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/fc_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fc_serializer (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 cfg_load,
    input  tlc_pkg::drv_state_t  state,
    input  logic [7:0]           bit_index,
    input  logic                 clk_enable,
    input  logic                 driver_sout,
    input  tlc_pkg::fc_config_t  cfg_head,
    input  logic                 cfg_present,
    output logic                 cfg_pop,
    output logic                 fc_bit,
    output logic                 config_match
);

    tlc_pkg::fc_config_t active;
    tlc_pkg::fc_config_t capture;
    logic [7:0] fc_pos;
    logic dump_shift;
    logic dump_last;
    logic dump_done;

    assign cfg_pop = cfg_load && cfg_present;

    // Bit 1 of CONFIG carries the MSB, index 0 is the SCLK pause
    assign fc_pos = 8'(tlc_pkg::FC_BITS) - bit_index;
    assign fc_bit = (state == tlc_pkg::CONFIG && bit_index != '0) ? active[fc_pos[5:0]] : 1'b0;

    // Read-back runs once the READFC pause is over
    assign dump_shift = clk_enable && state == tlc_pkg::DUMP_CONFIG
                        && bit_index >= 8'(tlc_pkg::DUMP_PAUSE);
    assign dump_last = dump_shift
                       && bit_index == 8'(tlc_pkg::FC_BITS + tlc_pkg::DUMP_PAUSE - 1);

    always_ff @(posedge clk) begin
        if (cfg_pop) begin
            active <= cfg_head;
        end
        // Drivers return the config MSB first as well
        if (dump_shift) begin
            capture <= {capture[tlc_pkg::FC_BITS-2:0], driver_sout};
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            dump_done <= 1'b0;
            config_match <= 1'b0;
        end else begin
            dump_done <= dump_last;
            // A new config is unverified until its read-back ends
            if (cfg_pop) begin
                config_match <= 1'b0;
            end else if (dump_done) begin
                config_match <= (capture == active);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/tlc_driver_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlc_driver_top #(
    parameter int BLANKING_TIME = 72,
    parameter int GS_DEPTH = 16,
    parameter int CFG_DEPTH = 2
) (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  clk_enable,
    input  logic                  gs_valid,
    input  tlc_pkg::gs_word_t     gs_word,
    output logic                  gs_credit,
    input  logic                  cfg_valid,
    input  tlc_pkg::fc_config_t   cfg_word,
    output logic                  cfg_credit,
    input  logic                  position_sync,
    input  logic                  driver_sout,
    output tlc_pkg::driver_pins_t pins,
    output logic                  column_ready,
    output logic                  config_match,
    output logic                  underrun
);

    tlc_pkg::gs_word_t gs_head;
    tlc_pkg::fc_config_t cfg_head;
    tlc_pkg::drv_state_t state;
    logic [7:0] bit_index;
    logic gs_present;
    logic gs_pop;
    logic cfg_present;
    logic cfg_pop;
    logic cfg_load;
    logic fc_bit;
    logic sclk_en;
    logic gclk_en;
    logic lat_req;
    logic gs_take;

    // Grayscale receive buffer
    credit_fifo #(
        .payload_t(tlc_pkg::gs_word_t),
        .DEPTH(GS_DEPTH)
    ) gs_fifo_inst (
        .clk(clk),
        .nrst(nrst),
        .push(gs_valid),
        .push_data(gs_word),
        .pop(gs_pop),
        .head(gs_head),
        .not_empty(gs_present),
        .credit(gs_credit)
    );

    // Configuration receive buffer
    credit_fifo #(
        .payload_t(tlc_pkg::fc_config_t),
        .DEPTH(CFG_DEPTH)
    ) cfg_fifo_inst (
        .clk(clk),
        .nrst(nrst),
        .push(cfg_valid),
        .push_data(cfg_word),
        .pop(cfg_pop),
        .head(cfg_head),
        .not_empty(cfg_present),
        .credit(cfg_credit)
    );

    fc_serializer fc_serializer_inst (
        .clk(clk),
        .nrst(nrst),
        .cfg_load(cfg_load),
        .state(state),
        .bit_index(bit_index),
        .clk_enable(clk_enable),
        .driver_sout(driver_sout),
        .cfg_head(cfg_head),
        .cfg_present(cfg_present),
        .cfg_pop(cfg_pop),
        .fc_bit(fc_bit),
        .config_match(config_match)
    );

    // A waiting config both starts boot and requests a restart
    driver_controller #(
        .BLANKING_TIME(BLANKING_TIME)
    ) driver_controller_inst (
        .clk(clk),
        .nrst(nrst),
        .clk_enable(clk_enable),
        .position_sync(position_sync),
        .cfg_present(cfg_present),
        .new_cfg(cfg_present),
        .state(state),
        .bit_index(bit_index),
        .sclk_en(sclk_en),
        .gclk_en(gclk_en),
        .lat_req(lat_req),
        .gs_take(gs_take),
        .cfg_load(cfg_load),
        .column_ready(column_ready)
    );

    driver_pin_mux driver_pin_mux_inst (
        .clk(clk),
        .nrst(nrst),
        .clk_enable(clk_enable),
        .state(state),
        .sclk_en(sclk_en),
        .gclk_en(gclk_en),
        .lat_req(lat_req),
        .gs_take(gs_take),
        .fc_bit(fc_bit),
        .gs_head(gs_head),
        .gs_present(gs_present),
        .gs_pop(gs_pop),
        .pins(pins),
        .underrun(underrun)
    );

endmodule

`default_nettype wire

// ==== design/tlc_pkg.sv ====
`default_nettype none

package tlc_pkg;

    // Driver chain geometry
    localparam int LANES = 30;
    localparam int FC_BITS = 48;

    // Segment is 512 GCLK pulses plus one pause after LATGS
    localparam int SEGMENT_LAST = 512;
    localparam int MUX_ROWS = 8;

    // LAT lengths in SCLK edges for each driver command
    localparam int FCWRTEN_LEN = 15;
    localparam int READFC_LEN = 11;
    localparam int WRTFC_LEN = 5;
    localparam int WRTGS_LEN = 1;
    localparam int LATGS_LEN = 3;

    // SCLK pause after READFC before sout is valid
    localparam int DUMP_PAUSE = 5;

    // One grayscale bit for every driver lane
    typedef logic [LANES-1:0] gs_word_t;

    // Function-control data, shifted MSB first
    typedef logic [FC_BITS-1:0] fc_config_t;

    typedef struct packed {
        logic sclk;
        logic gclk;
        logic lat;
        logic [LANES-1:0] sin;
    } driver_pins_t;

    // Sequencer states
    typedef enum logic [3:0] {
        STALL = 4'd0,
        PREPARE_CONFIG = 4'd1,
        CONFIG = 4'd2,
        STREAM = 4'd3,
        LOD = 4'd4,
        PREPARE_DUMP_CONFIG = 4'd5,
        DUMP_CONFIG = 4'd6,
        WRTFC_TIMING = 4'd7,
        WAIT_FOR_NEXT_SLICE = 4'd8
    } drv_state_t;

endpackage

`default_nettype wire

// ==== files.f ====
design/tlc_pkg.sv
design/credit_fifo.sv
design/fc_serializer.sv
design/driver_controller.sv
design/driver_pin_mux.sv
design/tlc_driver_top.sv
verification/driver_controller_assertions.sv
verification/tlc_driver_tb.sv

// ==== verification/driver_controller_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module driver_controller_assertions (
    input wire logic                clk,
    input wire logic                nrst,
    input wire tlc_pkg::drv_state_t state,
    input wire logic                gclk_en,
    input wire logic                column_ready,
    input wire logic                cfg_load,
    input wire logic                cfg_present
);

    // GCLK rests on the pulse after each column strobe
    gclk_paused_after_segment: assert property (
        @(posedge clk) disable iff (!nrst)
        column_ready |=> !gclk_en
    ) else $error("gclk_en not paused after segment end");

    // One column strobe per segment end
    column_ready_single: assert property (
        @(posedge clk) disable iff (!nrst)
        column_ready |=> !column_ready
    ) else $error("column_ready longer than one pulse");

    // A load needs a waiting config and restarts the boot sequence
    cfg_load_starts_config: assert property (
        @(posedge clk) disable iff (!nrst)
        cfg_load |-> cfg_present ##1 (state == tlc_pkg::PREPARE_CONFIG)
    ) else $error("cfg_load without config or without restart");

endmodule

`default_nettype wire

// ==== verification/tlc_driver_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlc_driver_tb;

    localparam int GS_DEPTH = 16;
    localparam int CFG_DEPTH = 2;
    localparam int BOOT_PULSES = 15 + 49 + 6 + 11 + 53 + 1;
    localparam int SLICE_PULSES = tlc_pkg::MUX_ROWS * (tlc_pkg::SEGMENT_LAST + 1);
    // Two boots and three slices at two clocks per pulse, plus margin
    localparam int TIMEOUT_CYCLES = 2 * (2 * BOOT_PULSES + 3 * SLICE_PULSES) + 4000;

    logic clk;
    logic nrst;
    logic clk_enable;
    logic gs_valid;
    tlc_pkg::gs_word_t gs_word;
    logic gs_credit;
    logic cfg_valid;
    tlc_pkg::fc_config_t cfg_word;
    logic cfg_credit;
    logic position_sync;
    logic driver_sout;
    tlc_pkg::driver_pins_t pins;
    logic column_ready;
    logic config_match;
    logic underrun;

    integer seed;
    int value_errors;
    int other_errors;
    int cycle_count;
    int gs_credits;
    int cfg_credits;
    int gs_sent;
    int gs_returned;
    int edge_num;
    int gclk_count;
    int column_count;
    int slices_done;
    int boots_done;
    logic gs_hold;
    logic cfg_req;
    logic cfg_seen;
    logic flip;
    logic exp_underrun;
    logic gs_pending_valid;
    tlc_pkg::gs_word_t gs_pending;
    tlc_pkg::gs_word_t gs_expected[$];
    tlc_pkg::fc_config_t cfg_next;
    tlc_pkg::fc_config_t exp_cfg;
    tlc_pkg::fc_config_t cap_cfg;
    tlc_pkg::fc_config_t model_cfg;
    tlc_pkg::drv_state_t prev_state;
    tlc_pkg::drv_state_t dut_state;
    logic [7:0] dut_bit_index;

    tlc_driver_top tlc_driver_top_inst (
        .clk(clk), .nrst(nrst), .clk_enable(clk_enable),
        .gs_valid(gs_valid), .gs_word(gs_word), .gs_credit(gs_credit),
        .cfg_valid(cfg_valid), .cfg_word(cfg_word), .cfg_credit(cfg_credit),
        .position_sync(position_sync), .driver_sout(driver_sout), .pins(pins),
        .column_ready(column_ready), .config_match(config_match), .underrun(underrun)
    );

    bind driver_controller driver_controller_assertions driver_controller_assertions_inst (
        .clk(clk), .nrst(nrst), .state(state), .gclk_en(gclk_en),
        .column_ready(column_ready), .cfg_load(cfg_load),
        .cfg_present(cfg_present)
    );

    // Sequencer position, used to frame the protocol phases
    assign dut_state = tlc_driver_top_inst.state;
    assign dut_bit_index = tlc_driver_top_inst.bit_index;

    // WRTFC covers the last configuration edges
    function automatic logic expected_lat(int edge_idx);
        return edge_idx >= tlc_pkg::FC_BITS - tlc_pkg::WRTFC_LEN;
    endfunction

    // Same configuration bit on every lane, MSB on the first edge
    function automatic tlc_pkg::gs_word_t config_lanes(tlc_pkg::fc_config_t cfg,
                                                       int edge_idx);
        return {tlc_pkg::LANES{cfg[tlc_pkg::FC_BITS - 1 - edge_idx]}};
    endfunction

    // Driver read-back, MSB first after the READFC pause
    function automatic logic replay_bit(tlc_pkg::fc_config_t cfg, logic [7:0] idx,
                                        logic do_flip);
        int pos;
        if (idx < 8'(tlc_pkg::DUMP_PAUSE)) begin
            return 1'b0;
        end
        pos = tlc_pkg::FC_BITS - 1 - (int'(idx) - tlc_pkg::DUMP_PAUSE);
        return cfg[pos] ^ (do_flip && pos == 20);
    endfunction

    task automatic check_gs(string name, tlc_pkg::gs_word_t got, tlc_pkg::gs_word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_cfg(string name, tlc_pkg::fc_config_t got,
                             tlc_pkg::fc_config_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            value_errors++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic send_config(tlc_pkg::fc_config_t value, logic do_flip);
        @(negedge clk);
        cfg_next <= value;
        flip <= do_flip;
        cfg_seen <= 1'b1;
        cfg_req <= 1'b1;
    endtask

    task automatic start_slice();
        @(negedge clk);
        position_sync = 1'b1;
        repeat (2) @(negedge clk);
        position_sync = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Sources, pacing pulse and driver read-back model
    always @(negedge clk) begin
        clk_enable = nrst ? !clk_enable : 1'b0;
        gs_valid = 1'b0;
        gs_pending_valid = 1'b0;
        if (nrst && !gs_hold && gs_credits > 0) begin
            gs_word = tlc_pkg::gs_word_t'($random(seed));
            gs_valid = 1'b1;
            gs_credits--;
            gs_sent++;
            gs_pending = gs_word;
            gs_pending_valid = 1'b1;
        end
        cfg_valid = 1'b0;
        if (nrst && cfg_req && cfg_credits > 0) begin
            cfg_word = cfg_next;
            cfg_valid = 1'b1;
            cfg_credits--;
            cfg_req = 1'b0;
            exp_cfg = cfg_next;
        end
        driver_sout = (dut_state == tlc_pkg::DUMP_CONFIG)
                      ? replay_bit(model_cfg, dut_bit_index, flip) : 1'b0;
    end

    // Compare process, samples just before the rising edge
    always @(negedge clk) begin
        #4;
        if (nrst) begin
            if (gs_credit) begin
                gs_credits++;
                gs_returned++;
            end
            if (cfg_credit) begin
                cfg_credits++;
            end
            if (gs_sent - gs_returned > GS_DEPTH || gs_sent - gs_returned < 0) begin
                other_errors++;
                $display("Grayscale words outstanding outside 0 to depth at %0t", $time);
            end
            if (!cfg_seen) begin
                check_bit("pins", |pins, 1'b0);
                check_bit("column_ready", column_ready, 1'b0);
                check_bit("config_match", config_match, 1'b0);
                check_bit("gs_credit", gs_credit, 1'b0);
                check_bit("cfg_credit", cfg_credit, 1'b0);
                check_bit("state_is_stall", dut_state == tlc_pkg::STALL, 1'b1);
            end
            if (dut_state == tlc_pkg::PREPARE_CONFIG) begin
                edge_num = 0;
            end
            if (dut_state == tlc_pkg::CONFIG && pins.sclk) begin
                check_gs("pins.sin", pins.sin, config_lanes(exp_cfg, edge_num));
                check_bit("pins.lat", pins.lat, expected_lat(edge_num));
                cap_cfg = {cap_cfg[tlc_pkg::FC_BITS-2:0], pins.sin[0]};
                edge_num++;
            end
            if (prev_state == tlc_pkg::CONFIG && dut_state != tlc_pkg::CONFIG) begin
                check_count("config_edges", edge_num, tlc_pkg::FC_BITS);
                check_cfg("config_shifted", cap_cfg, exp_cfg);
                model_cfg = cap_cfg;
            end
            if (prev_state == tlc_pkg::LOD && dut_state == tlc_pkg::WAIT_FOR_NEXT_SLICE) begin
                check_bit("config_match", config_match, !flip);
                boots_done++;
            end
            if (prev_state == tlc_pkg::WAIT_FOR_NEXT_SLICE && dut_state == tlc_pkg::STREAM) begin
                gclk_count = 0;
                column_count = 0;
            end
            check_bit("underrun", underrun, exp_underrun);
            if (dut_state == tlc_pkg::STREAM && pins.sclk) begin
                if (gs_expected.size() > 0) begin
                    check_gs("pins.sin", pins.sin, gs_expected.pop_front());
                end else begin
                    check_gs("pins.sin", pins.sin, '0);
                    exp_underrun = 1'b1;
                end
            end
            if (dut_state == tlc_pkg::STREAM && pins.gclk) begin
                gclk_count++;
            end
            if (column_ready) begin
                column_count++;
            end
            if (prev_state == tlc_pkg::STREAM && dut_state == tlc_pkg::WAIT_FOR_NEXT_SLICE) begin
                check_count("gclk_pulses", gclk_count,
                            tlc_pkg::MUX_ROWS * tlc_pkg::SEGMENT_LAST);
                check_count("column_ready_pulses", column_count, tlc_pkg::MUX_ROWS);
                slices_done++;
            end
            if (gs_pending_valid) begin
                gs_expected.push_back(gs_pending);
            end
            prev_state = dut_state;
        end
    end

    initial begin
        nrst = 1'b0;
        clk_enable = 1'b0;
        gs_valid = 1'b0;
        gs_word = '0;
        cfg_valid = 1'b0;
        cfg_word = '0;
        position_sync = 1'b0;
        driver_sout = 1'b0;
        seed = 32'h360c_33e0;
        value_errors = 0;
        other_errors = 0;
        cycle_count = 0;
        gs_credits = GS_DEPTH;
        cfg_credits = CFG_DEPTH;
        gs_sent = 0;
        gs_returned = 0;
        edge_num = 0;
        gclk_count = 0;
        column_count = 0;
        slices_done = 0;
        boots_done = 0;
        gs_hold = 1'b0;
        cfg_req = 1'b0;
        cfg_seen = 1'b0;
        flip = 1'b0;
        exp_underrun = 1'b0;
        gs_pending_valid = 1'b0;
        gs_pending = '0;
        cfg_next = '0;
        exp_cfg = '0;
        cap_cfg = '0;
        model_cfg = '0;
        prev_state = tlc_pkg::STALL;
        repeat (16) @(posedge clk);
        @(negedge clk);
        nrst <= 1'b1;
        // Idle window, nothing may move without a config
        repeat (40) @(negedge clk);
        send_config(48'hA5C3_0F96_1E2D, 1'b0);
        wait (boots_done == 1);
        start_slice();
        wait (slices_done == 1);
        // Second slice is cut short by a flipped reconfiguration
        start_slice();
        repeat (1200) @(negedge clk);
        send_config(48'h3C69_D2B4_8E71, 1'b1);
        wait (boots_done == 2);
        check_bit("underrun_before_hold", underrun, 1'b0);
        gs_hold = 1'b1;
        start_slice();
        wait (slices_done == 2);
        repeat (4) @(negedge clk);
        check_bit("underrun_seen", underrun, 1'b1);
        check_bit("config_match_after_flip", config_match, 1'b0);
        check_count("gs_outstanding", gs_sent - gs_returned, gs_expected.size());
        check_count("cfg_credits_returned", cfg_credits, CFG_DEPTH);
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
